// ==== verilog/qsnd_pkg.sv ====
/* Shared widths, register offsets and types for the QSound glue logic.
   Port offsets follow the CPU's 0xDxxx page. Only the low three address
   bits select a register, so the page repeats every eight bytes. */

package qsnd_pkg;

    localparam int sample_w = 16;           // one audio sample
    localparam int cmd_w    = 24;           // address byte + data word
    localparam int bank_w   = 4;
    localparam logic [3:0] qsnd_page = 4'hd;
    localparam int rate_max = 1999;         // 48 MHz / 2000 = 24 kHz

    typedef struct packed {
        logic [15:0] addr;
        logic [ 7:0] dout;
        logic        mreq_n;
        logic        rd_n;
        logic        wr_n;
    } z80_bus_t;

    // encoding equals the register offset, none sits in a free slot
    typedef enum logic [2:0] {
        SEL_DATA_HI = 3'd0,
        SEL_DATA_LO = 3'd1,
        SEL_ADDR    = 3'd2,
        SEL_BANK    = 3'd3,
        SEL_NONE    = 3'd4,
        SEL_STATUS  = 3'd7
    } port_sel_e;

    typedef struct packed {
        logic [cmd_w-sample_w-1:0] addr;
        logic [sample_w-1:0]       data;
    } dsp_cmd_t;

    typedef struct packed {
        logic signed [sample_w-1:0] left;
        logic signed [sample_w-1:0] right;
    } audio_frame_t;

    typedef enum logic {HALF_LEFT = 1'b0, HALF_RIGHT = 1'b1} rx_half_e;

endpackage

// ==== verilog/qsnd_port_decode.sv ====
/* CPU side register decode for the QSound page.
   Writes are level based, a held write just repeats. The bank nibble is
   only stored for the status port, no ROM banking happens here.
   Bank and DSP reset land one clock after the bank write is sampled. */

module qsnd_port_decode import qsnd_pkg::*; (
    input  logic              clk48,
    input  logic              rst,
    input  z80_bus_t          bus,
    input  logic              rdy_n,
    output port_sel_e         cmd_wr_sel,
    output logic [7:0]        wr_byte,
    output logic [bank_w-1:0] bank,
    output logic              dsp_rst,
    output logic [7:0]        rd_data
);

    logic       page_hit;
    logic [2:0] offset;
    port_sel_e  rd_sel;
    logic       bank_wr_q;     // bank write seen last clock
    logic [7:0] bank_byte_q;

    assign page_hit = !bus.mreq_n && bus.addr[15:12] == qsnd_page;
    assign offset   = bus.addr[2:0];
    assign wr_byte  = bus.dout;

    always_comb begin
        cmd_wr_sel = SEL_NONE;
        if (page_hit && !bus.wr_n) begin
            if (offset <= 3'd2) begin
                cmd_wr_sel = port_sel_e'(offset);   // data hi, data lo, address
            end else if (offset == 3'd3) begin
                cmd_wr_sel = SEL_BANK;
            end
        end
    end

    // only offset 7 returns anything
    assign rd_sel = (page_hit && !bus.rd_n && offset == 3'd7) ? SEL_STATUS : SEL_NONE;

    always_comb begin
        if (rd_sel == SEL_STATUS) begin
            rd_data = {rdy_n, 3'b111, bank};
        end else begin
            rd_data = 8'hff;                        // open bus
        end
    end

    always_ff @(posedge clk48) begin
        bank_byte_q <= bus.dout;
    end

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            bank_wr_q <= 1'b0;
            bank      <= '0;
            dsp_rst   <= 1'b1;                      // DSP held until the CPU releases it
        end else begin
            bank_wr_q <= cmd_wr_sel == SEL_BANK;
            if (bank_wr_q) begin
                bank    <= bank_byte_q[bank_w-1:0];
                dsp_rst <= ~bank_byte_q[7];
            end
        end
    end

endmodule

// ==== verilog/qsnd_mailbox.sv ====
/* Command mailbox between the sound CPU and the DSP parallel port.
   The CPU writes data high, data low, then the address byte, which
   raises irq. The DSP reads address first, then data, one per pids_n
   strobe. A new command simply overwrites one that was not read. */

module qsnd_mailbox import qsnd_pkg::*; (
    input  logic        clk48,
    input  logic        rst,
    input  port_sel_e   cmd_wr_sel,
    input  logic [7:0]  wr_byte,
    input  logic        pids_n,
    input  logic        iack,
    output logic        irq,
    output logic        rdy_n,
    output logic [15:0] pbus_in
);

    typedef enum logic [1:0] {SEQ_IDLE, SEQ_ADDR, SEQ_DATA} seq_e;

    logic [sample_w-1:0] data_q;    // data word being assembled by the CPU
    dsp_cmd_t            cmd_s;     // what the DSP sees
    seq_e                seq;
    logic                pids_q;
    logic                pids_rise;

    assign pids_rise = pids_n && !pids_q;
    assign rdy_n     = ~(irq | iack);

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            data_q <= '0;
            cmd_s  <= '0;
            irq    <= 1'b0;
            seq    <= SEQ_IDLE;
            pids_q <= 1'b1;
        end else begin
            pids_q <= pids_n;
            case (cmd_wr_sel)
                SEL_DATA_HI: data_q[15:8] <= wr_byte;
                SEL_DATA_LO: data_q[7:0]  <= wr_byte;
                default: ;
            endcase
            if (cmd_wr_sel == SEL_ADDR) begin
                cmd_s <= '{addr: wr_byte, data: data_q};
                irq   <= 1'b1;
                seq   <= SEQ_ADDR;
            end else if (pids_rise) begin
                irq <= 1'b0;
                // address -> data -> idle
                seq <= (seq == SEQ_ADDR) ? SEQ_DATA : SEQ_IDLE;
            end
        end
    end

    assign pbus_in = (seq == SEQ_ADDR) ? {8'h00, cmd_s.addr} : cmd_s.data;

endmodule

// ==== verilog/qsnd_serial_rx.sv ====
/* Deserialiser for the DSP serial output in the way a TDA1543 would.
   A falling sadd arms a 16 bit word and psel picks the channel. Bits are taken
   MSB first on ock falling edges. The frame is only released once both
   channels have a full word. */

module qsnd_serial_rx import qsnd_pkg::*; (
    input  logic         clk48,
    input  logic         rst,
    input  logic         sdo,
    input  logic         ock,
    input  logic         sadd,
    input  logic         psel,
    output audio_frame_t frame,
    output logic         frame_done
);

    logic                sadd_q;
    logic                ock_q;
    logic                sadd_fall;
    logic                ock_fall;
    logic [sample_w-1:0] arm_cnt;     // one set bit per bit still to come
    rx_half_e            half;
    logic [sample_w-1:0] shift_l;
    logic [sample_w-1:0] shift_r;
    logic                left_done;
    logic                right_done;

    assign sadd_fall = sadd_q && !sadd;
    assign ock_fall  = ock_q && !ock;

    // MSB first into the selected channel
    always_ff @(posedge clk48) begin
        if (ock_fall && arm_cnt[sample_w-1]) begin
            if (half == HALF_RIGHT) begin
                shift_r <= {shift_r[sample_w-2:0], sdo};
            end else begin
                shift_l <= {shift_l[sample_w-2:0], sdo};
            end
        end
    end

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            sadd_q     <= 1'b0;
            ock_q      <= 1'b0;
            arm_cnt    <= '0;
            half       <= HALF_LEFT;
            left_done  <= 1'b0;
            right_done <= 1'b0;
            frame      <= '0;
            frame_done <= 1'b0;
        end else begin
            sadd_q <= sadd;
            ock_q  <= ock;
            if (sadd_fall) begin
                half    <= rx_half_e'(psel);
                arm_cnt <= '1;
            end
            if (ock_fall && arm_cnt[sample_w-1]) begin
                arm_cnt <= arm_cnt << 1;
                if (!arm_cnt[sample_w-2]) begin     // last bit of the word
                    if (half == HALF_RIGHT) right_done <= 1'b1;
                    else                    left_done  <= 1'b1;
                end
            end
            if (left_done && right_done) begin
                frame      <= '{left: shift_l, right: shift_r};
                frame_done <= 1'b1;
                left_done  <= 1'b0;
                right_done <= 1'b0;
            end else begin
                frame_done <= 1'b0;
            end
        end
    end

endmodule

// ==== verilog/qsnd_rate_hold.sv ====
/* Fixed rate output stage, 24 kHz from clk48.
   The latest frame is released on every divider wrap, older unreleased
   frames are lost. After a frame the DSP clock enable is dropped until
   the next wrap, and it stays low while rom_ok is low. */

module qsnd_rate_hold import qsnd_pkg::*; (
    input  logic         clk48,
    input  logic         rst,
    input  audio_frame_t frame,
    input  logic         frame_done,
    input  logic         rom_ok,
    output audio_frame_t out_frame,
    output logic         sample,
    output logic         dsp_cen
);

    localparam int cnt_w = $clog2(rate_max + 1);

    logic [cnt_w-1:0] cnt;
    logic             wrap;
    logic             sleep;      // frame made, wait for the output tick

    assign wrap = cnt == cnt_w'(rate_max);

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            cnt       <= '0;
            sleep     <= 1'b0;
            sample    <= 1'b0;
            dsp_cen   <= 1'b1;
            out_frame <= '0;
        end else begin
            dsp_cen <= ~sleep & rom_ok;
            if (wrap) begin
                cnt       <= '0;
                sleep     <= 1'b0;
                sample    <= 1'b1;
                out_frame <= frame;
            end else begin
                cnt    <= cnt + 1'b1;
                sample <= 1'b0;
                if (frame_done) sleep <= 1'b1;
            end
        end
    end

endmodule

// ==== verilog/qsnd_glue.sv ====
/* QSound board glue, one clk48 domain.
   Host chain: CPU bus decode, command mailbox, DSP parallel port.
   Audio chain: DSP serial receiver, 24 kHz output stage.
   The CPU, the DSP and the sample ROM stay outside. */

module qsnd_glue import qsnd_pkg::*; (
    input  logic              clk48,
    input  logic              rst,
    input  z80_bus_t          bus,
    input  logic              pids_n,
    input  logic              iack,
    input  logic              sdo,
    input  logic              ock,
    input  logic              sadd,
    input  logic              psel,
    input  logic              rom_ok,
    output logic [7:0]        rd_data,
    output logic [bank_w-1:0] bank,
    output logic              dsp_rst,
    output logic              irq,
    output logic [15:0]       pbus_in,
    output audio_frame_t      out_frame,
    output logic              sample,
    output logic              dsp_cen
);

    port_sel_e    cmd_wr_sel;
    logic [7:0]   wr_byte;
    logic         rdy_n;
    audio_frame_t frame;
    logic         frame_done;

    // host chain
    qsnd_port_decode i_port_decode (
        .clk48      (clk48),
        .rst        (rst),
        .bus        (bus),
        .rdy_n      (rdy_n),
        .cmd_wr_sel (cmd_wr_sel),
        .wr_byte    (wr_byte),
        .bank       (bank),
        .dsp_rst    (dsp_rst),
        .rd_data    (rd_data)
    );

    qsnd_mailbox i_mailbox (
        .clk48      (clk48),
        .rst        (rst),
        .cmd_wr_sel (cmd_wr_sel),
        .wr_byte    (wr_byte),
        .pids_n     (pids_n),
        .iack       (iack),
        .irq        (irq),
        .rdy_n      (rdy_n),      // back to the status port
        .pbus_in    (pbus_in)
    );

    // audio chain
    qsnd_serial_rx i_serial_rx (
        .clk48      (clk48),
        .rst        (rst),
        .sdo        (sdo),
        .ock        (ock),
        .sadd       (sadd),
        .psel       (psel),
        .frame      (frame),
        .frame_done (frame_done)
    );

    qsnd_rate_hold i_rate_hold (
        .clk48      (clk48),
        .rst        (rst),
        .frame      (frame),
        .frame_done (frame_done),
        .rom_ok     (rom_ok),
        .out_frame  (out_frame),
        .sample     (sample),
        .dsp_cen    (dsp_cen)
    );

endmodule

// ==== bench/qsnd_glue_tb.sv ====
/* Testbench for the QSound glue. CPU writes, DSP strobes and serial frames
   come from a fixed seed and are checked against a small model kept here.
   CPU and DSP are bus-level stimulus only, no cores. */

module qsnd_glue_tb import qsnd_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_period    = 4;
    localparam int n_cmds        = 6;
    localparam int n_frames      = 36;
    localparam int host_cycles   = 800;      // bank and mailbox tests
    localparam int audio_periods = 40;
    localparam int margin_cycles = 2000;
    localparam z80_bus_t bus_idle = '{addr: 16'h0000, dout: 8'hff,
                                      mreq_n: 1'b1, rd_n: 1'b1, wr_n: 1'b1};

    logic         clk48;
    logic         rst;
    z80_bus_t     bus;
    logic         pids_n, iack, sdo, ock, sadd, psel, rom_ok;
    logic [7:0]   rd_data;
    logic [3:0]   bank;
    logic         dsp_rst, irq, sample, dsp_cen;
    logic [15:0]  pbus_in;
    audio_frame_t out_frame;

    integer       seed;
    int           checks = 0;
    int           mismatches = 0;
    int           failures = 0;
    logic         rom_ok_q;
    int           since_sample = 0;
    bit           sample_seen = 1'b0;
    logic [7:0]   b;
    logic [15:0]  l, r;
    int           n;

    // reference model
    logic [3:0]   m_bank;
    logic [15:0]  m_data;
    dsp_cmd_t     m_snap;
    bit           m_irq;
    int           m_seq;                     // 0 idle, 1 address next, 2 data next

    qsnd_glue i_qsnd_glue (.*);

    always #(clk_period / 2) clk48 = ~clk48;

    task automatic expect_equal(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            mismatches++;
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic report_failure(input string what);
        failures++;
        $display("error at %0t ns: %s", $time, what);
    endtask

    task automatic cpu_write(input logic [2:0] offset, input logic [7:0] data);
        @(posedge clk48);
        bus <= '{addr: {qsnd_page, 9'($random(seed)), offset}, dout: data,
                 mreq_n: 1'b0, rd_n: 1'b1, wr_n: 1'b0};
        @(posedge clk48);
        bus <= bus_idle;
    endtask

    task automatic read_status(input string name);
        @(posedge clk48);
        bus <= '{addr: {qsnd_page, 9'($random(seed)), 3'd7}, dout: 8'h00,
                 mreq_n: 1'b0, rd_n: 1'b0, wr_n: 1'b1};
        @(negedge clk48);
        expect_equal(name, {~(m_irq | iack), 3'b111, m_bank}, rd_data);
        @(posedge clk48);
        bus <= bus_idle;
    endtask

    // DSP reads pbus_in while the strobe is low
    task automatic pulse_pids();
        @(posedge clk48);
        pids_n <= 1'b0;
        @(negedge clk48);
        expect_equal("pbus_in", (m_seq == 1) ? {8'h00, m_snap.addr} : m_snap.data, pbus_in);
        @(posedge clk48);
        pids_n <= 1'b1;
        @(posedge clk48);                     // rise seen one clock late
        m_irq = 1'b0;
        m_seq = (m_seq == 1) ? 2 : 0;
        @(negedge clk48);
        expect_equal("irq after strobe", m_irq, irq);
    endtask

    task automatic send_word(input rx_half_e half, input logic [15:0] w);
        @(posedge clk48);
        psel <= half;
        sadd <= 1'b0;                         // arms the word
        for (int i = 15; i >= 0; i--) begin
            @(posedge clk48);
            sdo <= w[i];
            ock <= 1'b1;
            @(posedge clk48);
            ock <= 1'b0;
        end
        @(posedge clk48);
        sadd <= 1'b1;
    endtask

    task automatic wait_sample(input bit asleep);
        int  cnt = 0;
        bit  woke = 1'b0;
        do begin
            @(negedge clk48);
            cnt++;
            if (asleep && dsp_cen) woke = 1'b1;
        end while (!sample && cnt <= rate_max + 4);
        assert (sample) else report_failure("no sample pulse within one output period");
        assert (!woke) else report_failure("dsp_cen rose before the next sample");
    endtask

    always @(posedge clk48) rom_ok_q <= rom_ok;

    always @(negedge clk48) begin
        if (!rst) begin
            assert (rom_ok_q || !dsp_cen) else report_failure("dsp_cen high with rom_ok low");
            since_sample++;
            if (sample) begin
                if (sample_seen) expect_equal("sample period", rate_max + 1, since_sample);
                sample_seen  = 1'b1;
                since_sample = 0;
            end
        end
    end

    initial begin
        seed   = 32'h3049_f3c8;
        clk48  = 1'b0;
        rst    = 1'b1;
        bus    = bus_idle;
        pids_n = 1'b1;
        iack   = 1'b0;
        sdo    = 1'b0;
        ock    = 1'b0;
        sadd   = 1'b1;
        psel   = 1'b0;
        rom_ok = 1'b1;
        m_bank = '0;
        m_data = '0;
        m_snap = '0;
        m_irq  = 1'b0;
        m_seq  = 0;
        repeat (7) @(posedge clk48);
        @(negedge clk48);
        expect_equal("reset irq", 0, irq);
        expect_equal("reset dsp_rst", 1, dsp_rst);
        expect_equal("reset bank", 0, bank);
        expect_equal("reset sample", 0, sample);
        expect_equal("reset dsp_cen", 1, dsp_cen);
        expect_equal("reset out_frame", 0, out_frame);
        @(posedge clk48);
        rst <= 1'b0;

        // bank, DSP reset and status port
        for (int i = 0; i < 8; i++) begin
            b = 8'($random(seed));
            cpu_write(3'd3, b);
            m_bank = b[3:0];
            @(posedge clk48);
            @(negedge clk48);
            expect_equal("bank", m_bank, bank);
            expect_equal("dsp_rst", !b[7], dsp_rst);
            read_status("status idle");
        end

        // command mailbox toward the DSP
        for (int i = 0; i < n_cmds; i++) begin
            if (i == 0 || ($random(seed) & 1)) begin
                b = 8'($random(seed));
                cpu_write(3'd0, b);
                m_data[15:8] = b;
            end
            if (i == 0 || ($random(seed) & 1)) begin
                b = 8'($random(seed));
                cpu_write(3'd1, b);
                m_data[7:0] = b;
            end
            b = 8'($random(seed));
            cpu_write(3'd2, b);
            m_snap = '{addr: b, data: m_data};
            m_irq  = 1'b1;
            m_seq  = 1;
            @(negedge clk48);
            expect_equal("irq after command", m_irq, irq);
            read_status("status with irq");
            pulse_pids();
            pulse_pids();
            @(posedge clk48);
            iack <= 1'b1;
            read_status("status with iack");
            @(posedge clk48);
            iack <= 1'b0;
            read_status("status idle");
        end

        // serial frames, output rate and DSP sleep
        wait_sample(1'b0);
        for (int f = 0; f < n_frames; f++) begin
            @(posedge clk48);
            rom_ok <= ($random(seed) & 3) != 0;
            l = 16'($random(seed));
            r = 16'($random(seed));
            if ($random(seed) & 1) begin
                send_word(HALF_RIGHT, r);
                send_word(HALF_LEFT, l);
            end else begin
                send_word(HALF_LEFT, l);
                send_word(HALF_RIGHT, r);
            end
            n = 0;
            do begin
                @(negedge clk48);
                n++;
            end while (dsp_cen && n < 4);
            assert (!dsp_cen) else report_failure("dsp_cen still high after a frame");
            wait_sample(1'b1);
            expect_equal("out_frame", {l, r}, out_frame);
            @(negedge clk48);
            expect_equal("dsp_cen after sample", rom_ok, dsp_cen);
        end

        repeat (4) @(posedge clk48);
        $display("checks %0d, mismatches %0d, other failures %0d",
                 checks, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #((host_cycles + audio_periods * (rate_max + 1) + margin_cycles) * clk_period);
        $display("timeout, run did not finish; checks %0d, mismatches %0d, other failures %0d",
                 checks, mismatches, failures);
        $display("Checks failed");
        $finish;
    end

endmodule

// ==== qsnd_glue.f ====
verilog/qsnd_pkg.sv
verilog/qsnd_port_decode.sv
verilog/qsnd_mailbox.sv
verilog/qsnd_serial_rx.sv
verilog/qsnd_rate_hold.sv
verilog/qsnd_glue.sv
bench/qsnd_glue_tb.sv

// ==== Bender.yml ====
package:
  name: qsnd_glue

sources:
  # package first, then the RTL in dependency order
  - verilog/qsnd_pkg.sv
  - verilog/qsnd_port_decode.sv
  - verilog/qsnd_mailbox.sv
  - verilog/qsnd_serial_rx.sv
  - verilog/qsnd_rate_hold.sv
  - verilog/qsnd_glue.sv
  - target: simulation
    files:
      - bench/qsnd_glue_tb.sv
